// File: common/zport_consts.svh
//////////////////////////////////////////////////////////////////////
// z80 port block constants
// port addresses, xt register indices, reset values and masks
//////////////////////////////////////////////////////////////////////
`ifndef ZPORT_CONSTS_SVH
`define ZPORT_CONSTS_SVH

// low address byte of each port
`define ZP_FE          8'hFE
`define ZP_F6          8'hF6
`define ZP_AF          8'hAF
`define ZP_FD          8'hFD
`define ZP_F7          8'hF7
`define ZP_BE          8'hBE
`define ZP_KJOY        8'h1F
`define ZP_KMOUSE      8'hDF

// xt register indices (high byte of #nnAF)
`define ZP_XSTAT       8'h00
`define ZP_RAMPAGE     8'h10 // #10..#13
`define ZP_FMADDR      8'h15
`define ZP_SYSCONF     8'h20
`define ZP_MEMCONF     8'h21
`define ZP_IM2VECT     8'h25
`define ZP_XTOVERR     8'h2A

// xxBE read-back sub-ports, a[11:8]
`define ZP_BE_P7FFD    4'hA
`define ZP_BE_PEFF7    4'hB

`define ZP_RST_SYSCONF 8'h01 // turbo 7 MHz
`define ZP_RST_IM2VECT 8'hFF
`define ZP_RST_PAGE0   8'h00
`define ZP_RST_PAGE1   8'h05
`define ZP_RST_PAGE2   8'h02
`define ZP_RST_PAGE3   8'h00

`define ZP_PEFF7_MASK  8'b10110001 // applied while 1M is blocked
`define ZP_IDLE_BYTE   8'hFF

`endif

// File: common/zport_pkg.sv
//////////////////////////////////////////////////////////////////////
// z80 port block types
// bus vectors and the decoded port select
//////////////////////////////////////////////////////////////////////
package zport_pkg;

	typedef logic [15:0] zaddr_t;    // z80 address bus
	typedef logic [7:0]  zdata_t;    // z80 data byte
	typedef logic [7:0]  xt_index_t; // high address byte
	typedef logic [7:0]  page_t;     // one ram page number
	typedef logic [31:0] xt_page_t;  // pages 3..0 packed

	// target of a decoded i/o access
	typedef enum logic [2:0]
	{
		SEL_NONE,
		SEL_KBD,
		SEL_XT,
		SEL_7FFD,
		SEL_EFF7,
		SEL_BE,
		SEL_KJOY,
		SEL_KMOUSE
	} port_sel_e;

endpackage

// File: common/access_ifs.sv
//////////////////////////////////////////////////////////////////////
// pipeline interfaces of the port block
//////////////////////////////////////////////////////////////////////

// raw i/o access from the bus synchronizer
interface bus_access_if;
	logic              valid; // one-cycle pulse
	logic              write;
	zport_pkg::zaddr_t addr;
	zport_pkg::zdata_t data;

	modport src (output valid, output write, output addr, output data);
	modport dst (input valid, input write, input addr, input data);
endinterface

// access after address decode
interface decoded_access_if;
	logic                 valid;
	logic                 write;
	zport_pkg::port_sel_e sel;
	zport_pkg::xt_index_t index;
	zport_pkg::zdata_t    data;

	modport src (output valid, output write, output sel, output index, output data);
	modport dst (input valid, input write, input sel, input index, input data);
endinterface

// register contents needed by the read-back mux
interface reg_view_if;
	zport_pkg::page_t  page2;
	zport_pkg::page_t  page3;
	zport_pkg::zdata_t p7ffd;
	zport_pkg::zdata_t peff7_raw; // unmasked eff7

	modport src (output page2, output page3, output p7ffd, output peff7_raw);
	modport dst (input page2, input page3, input p7ffd, input peff7_raw);
endinterface

// File: hw/zbus_sync.sv
//////////////////////////////////////////////////////////////////////
// z80 i/o cycle synchronizer
// one-cycle access strobe with captured address, data and direction
//////////////////////////////////////////////////////////////////////
module zbus_sync
(
	input  logic              zclk,
	input  logic              rst_n,
	input  zport_pkg::zaddr_t a,
	input  zport_pkg::zdata_t din,
	input  logic              iorq_n,
	input  logic              rd_n,
	input  logic              wr_n,
	bus_access_if.src         acc
);

	logic iord;
	logic iowr;
	logic iord_d; // level seen at previous edge
	logic iowr_d;
	logic rd_start;
	logic wr_start;

	assign iord = !iorq_n && !rd_n;
	assign iowr = !iorq_n && !wr_n;

	// new cycle only when the level was inactive before
	assign rd_start = iord && !iord_d;
	assign wr_start = iowr && !iowr_d;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			iord_d    <= 1'b0;
			iowr_d    <= 1'b0;
			acc.valid <= 1'b0;
		end
		else
		begin
			iord_d    <= iord;
			iowr_d    <= iowr;
			acc.valid <= rd_start || wr_start;
		end
	end

	// payload, held until the next cycle begins
	always_ff @(posedge zclk)
	begin
		if (rd_start || wr_start)
		begin
			acc.addr  <= a;
			acc.data  <= din;
			acc.write <= wr_start;
		end
	end

endmodule

// File: hw/port_decode.sv
//////////////////////////////////////////////////////////////////////
// port address decoder
// classifies each access into a port select, registered
//////////////////////////////////////////////////////////////////////
`include "zport_consts.svh"

module port_decode
(
	input  logic          zclk,
	input  logic          rst_n,
	input  logic          dos,   // shadow mode
	bus_access_if.dst     bus,
	decoded_access_if.src dec
);

	zport_pkg::zdata_t    loa;
	zport_pkg::port_sel_e sel_next;

	assign loa = bus.addr[7:0];

	always_comb
	begin
		case (loa)
			`ZP_FE,
			`ZP_F6:
				sel_next = zport_pkg::SEL_KBD;
			`ZP_AF:
				sel_next = zport_pkg::SEL_XT;
			`ZP_FD: // a15 high belongs to the ay
				sel_next = bus.addr[15] ? zport_pkg::SEL_NONE : zport_pkg::SEL_7FFD;
			`ZP_F7:
			begin
				// eff7 only outside shadow mode
				if (bus.addr[8] && !bus.addr[12] && !dos)
					sel_next = zport_pkg::SEL_EFF7;
				else
					sel_next = zport_pkg::SEL_NONE;
			end
			`ZP_BE:
				sel_next = zport_pkg::SEL_BE;
			`ZP_KJOY: // vg93 command port in shadow mode
				sel_next = dos ? zport_pkg::SEL_NONE : zport_pkg::SEL_KJOY;
			`ZP_KMOUSE:
				sel_next = zport_pkg::SEL_KMOUSE;
			default:
				sel_next = zport_pkg::SEL_NONE;
		endcase
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			dec.valid <= 1'b0;
			dec.sel   <= zport_pkg::SEL_NONE;
		end
		else
		begin
			dec.valid <= bus.valid;
			if (bus.valid)
				dec.sel <= sel_next;
		end
	end

	always_ff @(posedge zclk)
	begin
		if (bus.valid)
		begin
			dec.write <= bus.write;
			dec.index <= bus.addr[15:8]; // hoa
			dec.data  <= bus.data;
		end
	end

endmodule

// File: hw/xt_regs/xt_regs.sv
//////////////////////////////////////////////////////////////////////
// configuration register file
// xt registers plus the 7FFD and EFF7 memory ports
//////////////////////////////////////////////////////////////////////
`include "zport_consts.svh"

module xt_regs
(
	input  logic                zclk,
	input  logic                rst_n,
	decoded_access_if.dst       dec,
	reg_view_if.src             view,
	output zport_pkg::xt_page_t xt_page,
	output logic [3:0]          xt_override,
	output logic [4:0]          fmaddr,
	output zport_pkg::zdata_t   sysconf,
	output zport_pkg::zdata_t   memconf,
	output zport_pkg::zdata_t   im2vect,
	output zport_pkg::zdata_t   peff7,
	output logic                romrw_en,
	output logic                pent1m_rom,
	output logic                pent1m_1m_on,
	output logic                pent1m_ram0_0
);

	zport_pkg::page_t  rampage [0:3];
	zport_pkg::zdata_t p7ffd;
	zport_pkg::zdata_t peff7_raw;
	logic              lock128;
	logic              xt_wr;

	assign lock128 = (memconf[7:6] == 2'b01);
	assign xt_wr   = dec.valid && dec.write && (dec.sel == zport_pkg::SEL_XT);

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			rampage[0]  <= `ZP_RST_PAGE0;
			rampage[1]  <= `ZP_RST_PAGE1;
			rampage[2]  <= `ZP_RST_PAGE2;
			rampage[3]  <= `ZP_RST_PAGE3;
			xt_override <= 4'b0000;
			fmaddr      <= 5'd0;
			sysconf     <= `ZP_RST_SYSCONF;
			memconf     <= 8'h00;
			im2vect     <= `ZP_RST_IM2VECT;
			p7ffd       <= 8'h00;
			peff7_raw   <= 8'h00;
		end
		else if (xt_wr)
		begin
			// page write switches that window to xt paging
			if ((dec.index & 8'hFC) == `ZP_RAMPAGE)
			begin
				rampage[dec.index[1:0]]     <= dec.data;
				xt_override[dec.index[1:0]] <= 1'b1;
			end
			if (dec.index == `ZP_XTOVERR)
				xt_override <= dec.data[3:0];
			if (dec.index == `ZP_FMADDR)
				fmaddr <= dec.data[4:0];
			if (dec.index == `ZP_SYSCONF)
				sysconf <= dec.data;
			if (dec.index == `ZP_MEMCONF)
				memconf <= dec.data;
			if (dec.index == `ZP_IM2VECT)
				im2vect <= dec.data;
		end
		else if (dec.valid && dec.write && (dec.sel == zport_pkg::SEL_7FFD) && !p7ffd[5])
		begin
			p7ffd      <= dec.data;
			memconf[0] <= dec.data[4]; // rom select
			rampage[3] <= {3'b000, lock128 ? 2'b00 : dec.data[7:6], dec.data[2:0]};
		end
		else if (dec.valid && dec.write && (dec.sel == zport_pkg::SEL_EFF7))
			peff7_raw <= dec.data;
	end

	assign xt_page = {rampage[3], rampage[2], rampage[1], rampage[0]};

	// bit 2 of eff7 blocks the 1M extension
	assign peff7         = peff7_raw[2] ? (peff7_raw & `ZP_PEFF7_MASK) : peff7_raw;
	assign pent1m_1m_on  = ~peff7_raw[2];
	assign pent1m_ram0_0 = peff7_raw[3];
	assign romrw_en      = memconf[1];
	assign pent1m_rom    = memconf[0];

	assign view.page2     = rampage[2];
	assign view.page3     = rampage[3];
	assign view.p7ffd     = p7ffd;
	assign view.peff7_raw = peff7_raw;

endmodule

// File: hw/xt_regs/port_readback.sv
//////////////////////////////////////////////////////////////////////
// read data multiplexer
// registered byte for the z80 with a one-cycle valid
//////////////////////////////////////////////////////////////////////
`include "zport_consts.svh"

module port_readback
(
	input  logic              zclk,
	input  logic              rst_n,
	decoded_access_if.dst     dec,
	reg_view_if.dst           view,
	input  logic [4:0]        keys_in,   // fe keys
	input  logic              tape_read,
	input  logic [4:0]        kj_in,     // kempston joystick
	input  zport_pkg::zdata_t mus_in,    // kempston mouse
	input  logic              dma_act,
	output zport_pkg::zdata_t rd_data,
	output logic              rd_valid
);

	zport_pkg::zdata_t rd_byte;

	always_comb
	begin
		rd_byte = `ZP_IDLE_BYTE;
		case (dec.sel)
			zport_pkg::SEL_KBD:
				rd_byte = {1'b1, tape_read, 1'b0, keys_in};
			zport_pkg::SEL_XT:
			begin
				if (dec.index == `ZP_XSTAT)
					rd_byte = {dma_act, 7'b0000000};
				else if (dec.index == `ZP_RAMPAGE + 8'd2)
					rd_byte = view.page2;
				else if (dec.index == `ZP_RAMPAGE + 8'd3)
					rd_byte = view.page3;
			end
			zport_pkg::SEL_KJOY:
				rd_byte = {3'b000, kj_in};
			zport_pkg::SEL_KMOUSE:
				rd_byte = mus_in;
			zport_pkg::SEL_BE:
			begin
				if (dec.index[3:0] == `ZP_BE_P7FFD)
					rd_byte = view.p7ffd;
				else if (dec.index[3:0] == `ZP_BE_PEFF7)
					rd_byte = view.peff7_raw;
			end
			default:
				rd_byte = `ZP_IDLE_BYTE;
		endcase
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			rd_valid <= 1'b0;
		else
			rd_valid <= dec.valid && !dec.write;
	end

	always_ff @(posedge zclk)
	begin
		if (dec.valid && !dec.write)
			rd_data <= rd_byte;
	end

endmodule

// File: hw/zports_top.sv
//////////////////////////////////////////////////////////////////////
// z80 i/o port block, top level
//////////////////////////////////////////////////////////////////////
module zports_top
(
	input  logic                zclk,
	input  logic                rst_n,
	input  zport_pkg::zaddr_t   a,
	input  zport_pkg::zdata_t   din,
	input  logic                iorq_n,
	input  logic                rd_n,
	input  logic                wr_n,
	input  logic                dos,
	input  logic [4:0]          keys_in,
	input  logic                tape_read,
	input  logic [4:0]          kj_in,
	input  zport_pkg::zdata_t   mus_in,
	input  logic                dma_act,
	output zport_pkg::zdata_t   rd_data,
	output logic                rd_valid,
	output zport_pkg::xt_page_t xt_page,
	output logic [3:0]          xt_override,
	output logic [4:0]          fmaddr,
	output zport_pkg::zdata_t   sysconf,
	output zport_pkg::zdata_t   memconf,
	output zport_pkg::zdata_t   im2vect,
	output zport_pkg::zdata_t   peff7,
	output logic                romrw_en,
	output logic                pent1m_rom,
	output logic                pent1m_1m_on,
	output logic                pent1m_ram0_0
);

	bus_access_if     bus_acc ();
	decoded_access_if dec_acc ();
	reg_view_if       reg_view ();

	// stage 1
	zbus_sync u_zbus_sync
	(
		.zclk   (zclk),
		.rst_n  (rst_n),
		.a      (a),
		.din    (din),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.acc    (bus_acc.src)
	);

	// stage 2
	port_decode u_port_decode
	(
		.zclk  (zclk),
		.rst_n (rst_n),
		.dos   (dos),
		.bus   (bus_acc.dst),
		.dec   (dec_acc.src)
	);

	// stage 3, registers and read-back side by side
	xt_regs u_xt_regs
	(
		.zclk          (zclk),
		.rst_n         (rst_n),
		.dec           (dec_acc.dst),
		.view          (reg_view.src),
		.xt_page       (xt_page),
		.xt_override   (xt_override),
		.fmaddr        (fmaddr),
		.sysconf       (sysconf),
		.memconf       (memconf),
		.im2vect       (im2vect),
		.peff7         (peff7),
		.romrw_en      (romrw_en),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	port_readback u_port_readback
	(
		.zclk      (zclk),
		.rst_n     (rst_n),
		.dec       (dec_acc.dst),
		.view      (reg_view.dst),
		.keys_in   (keys_in),
		.tape_read (tape_read),
		.kj_in     (kj_in),
		.mus_in    (mus_in),
		.dma_act   (dma_act),
		.rd_data   (rd_data),
		.rd_valid  (rd_valid)
	);

endmodule

// File: tests/zports_tb.sv
//////////////////////////////////////////////////////////////////////
// testbench for the z80 i/o port block
// z80 cycles on the bus, shadow register model, directed and random
//////////////////////////////////////////////////////////////////////
`include "zport_consts.svh"

module zports_tb;

	localparam int max_cycles = 6000; // ~400 ops of up to 7 cycles, with margin

	logic        zclk;
	logic        rst_n;
	logic [15:0] a;
	logic [7:0]  din;
	logic        iorq_n;
	logic        rd_n;
	logic        wr_n;
	logic        dos;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [4:0]  kj_in;
	logic [7:0]  mus_in;
	logic        dma_act;
	logic [7:0]  rd_data;
	logic        rd_valid;
	logic [31:0] xt_page;
	logic [3:0]  xt_override;
	logic [4:0]  fmaddr;
	logic [7:0]  sysconf;
	logic [7:0]  memconf;
	logic [7:0]  im2vect;
	logic [7:0]  peff7;
	logic        romrw_en;
	logic        pent1m_rom;
	logic        pent1m_1m_on;
	logic        pent1m_ram0_0;

	// shadow copies of the register file
	logic [7:0]  m_page [0:3];
	logic [3:0]  m_over;
	logic [4:0]  m_fmaddr;
	logic [7:0]  m_sysconf;
	logic [7:0]  m_memconf;
	logic [7:0]  m_im2vect;
	logic [7:0]  m_p7ffd;
	logic [7:0]  m_peff7_raw;

	integer      seed;
	integer      errors;
	int          cycles;
	int          n;
	logic [31:0] r;
	logic [31:0] r2;
	logic [7:0]  lo;
	logic [7:0]  hi;
	logic [7:0]  d;

	zports_top UUT
	(
		.zclk          (zclk),
		.rst_n         (rst_n),
		.a             (a),
		.din           (din),
		.iorq_n        (iorq_n),
		.rd_n          (rd_n),
		.wr_n          (wr_n),
		.dos           (dos),
		.keys_in       (keys_in),
		.tape_read     (tape_read),
		.kj_in         (kj_in),
		.mus_in        (mus_in),
		.dma_act       (dma_act),
		.rd_data       (rd_data),
		.rd_valid      (rd_valid),
		.xt_page       (xt_page),
		.xt_override   (xt_override),
		.fmaddr        (fmaddr),
		.sysconf       (sysconf),
		.memconf       (memconf),
		.im2vect       (im2vect),
		.peff7         (peff7),
		.romrw_en      (romrw_en),
		.pent1m_rom    (pent1m_rom),
		.pent1m_1m_on  (pent1m_1m_on),
		.pent1m_ram0_0 (pent1m_ram0_0)
	);

	initial
	begin
		zclk = 1'b0;
		forever #20 zclk = ~zclk;
	end

	// run limit
	always @(posedge zclk)
	begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles)
		begin
			$display("timeout: run did not finish within %0d cycles", max_cycles);
			$display("TEST FAILED");
			$finish;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// reference model
	//////////////////////////////////////////////////////////////////////

	task model_reset;
		m_page[0]   = `ZP_RST_PAGE0;
		m_page[1]   = `ZP_RST_PAGE1;
		m_page[2]   = `ZP_RST_PAGE2;
		m_page[3]   = `ZP_RST_PAGE3;
		m_over      = 4'b0000;
		m_fmaddr    = 5'd0;
		m_sysconf   = `ZP_RST_SYSCONF;
		m_memconf   = 8'h00;
		m_im2vect   = `ZP_RST_IM2VECT;
		m_p7ffd     = 8'h00;
		m_peff7_raw = 8'h00;
	endtask

	task model_write(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] l;
		logic [7:0] h;
		l = addr[7:0];
		h = addr[15:8];
		if (l == `ZP_AF)
		begin
			if (h >= 8'h10 && h <= 8'h13)
			begin
				m_page[h[1:0]] = data;
				m_over[h[1:0]] = 1'b1;
			end
			if (h == `ZP_XTOVERR)
				m_over = data[3:0];
			if (h == `ZP_FMADDR)
				m_fmaddr = data[4:0];
			if (h == `ZP_SYSCONF)
				m_sysconf = data;
			if (h == `ZP_MEMCONF)
				m_memconf = data;
			if (h == `ZP_IM2VECT)
				m_im2vect = data;
		end
		else if (l == `ZP_FD && !addr[15] && !m_p7ffd[5])
		begin
			// lock128 drops the upper page bits
			m_page[3]    = {3'b000, (m_memconf[7:6] == 2'b01) ? 2'b00 : data[7:6], data[2:0]};
			m_memconf[0] = data[4];
			m_p7ffd      = data;
		end
		else if (l == `ZP_F7 && addr[8] && !addr[12] && !dos)
			m_peff7_raw = data;
	endtask

	function logic [7:0] read_value(input logic [15:0] addr);
		logic [7:0] l;
		logic [7:0] h;
		logic [7:0] v;
		l = addr[7:0];
		h = addr[15:8];
		v = 8'hFF;
		if (l == `ZP_FE || l == `ZP_F6)
			v = {1'b1, tape_read, 1'b0, keys_in};
		else if (l == `ZP_AF)
		begin
			if (h == 8'h00)
				v = {dma_act, 7'b0000000};
			else if (h == 8'h12)
				v = m_page[2];
			else if (h == 8'h13)
				v = m_page[3];
		end
		else if (l == `ZP_BE && h[3:0] == 4'hA)
			v = m_p7ffd;
		else if (l == `ZP_BE && h[3:0] == 4'hB)
			v = m_peff7_raw;
		else if (l == `ZP_KJOY && !dos)
			v = {3'b000, kj_in};
		else if (l == `ZP_KMOUSE)
			v = mus_in;
		return v;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// checks and bus cycles
	//////////////////////////////////////////////////////////////////////

	task check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task check_regs;
		logic [7:0] peff7_exp;
		peff7_exp = m_peff7_raw[2] ? (m_peff7_raw & `ZP_PEFF7_MASK) : m_peff7_raw;
		check_val("xt_page", xt_page, {m_page[3], m_page[2], m_page[1], m_page[0]});
		check_val("xt_override", 32'(xt_override), 32'(m_over));
		check_val("fmaddr", 32'(fmaddr), 32'(m_fmaddr));
		check_val("sysconf", 32'(sysconf), 32'(m_sysconf));
		check_val("memconf", 32'(memconf), 32'(m_memconf));
		check_val("im2vect", 32'(im2vect), 32'(m_im2vect));
		check_val("peff7", 32'(peff7), 32'(peff7_exp));
		check_val("romrw_en", 32'(romrw_en), 32'(m_memconf[1]));
		check_val("pent1m_rom", 32'(pent1m_rom), 32'(m_memconf[0]));
		check_val("pent1m_1m_on", 32'(pent1m_1m_on), 32'(!m_peff7_raw[2]));
		check_val("pent1m_ram0_0", 32'(pent1m_ram0_0), 32'(m_peff7_raw[3]));
	endtask

	task apply_reset;
		@(posedge zclk);
		rst_n <= 1'b0;
		repeat (4) @(posedge zclk);
		rst_n <= 1'b1;
		model_reset();
	endtask

	task set_inputs(input logic dos_v, input logic [4:0] keys_v, input logic tape_v,
			input logic [4:0] kj_v, input logic [7:0] mus_v, input logic dma_v);
		@(posedge zclk);
		dos       <= dos_v;
		keys_in   <= keys_v;
		tape_read <= tape_v;
		kj_in     <= kj_v;
		mus_in    <= mus_v;
		dma_act   <= dma_v;
	endtask

	// 3 cycles active, 2 idle, no read data expected
	task io_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge zclk);
		a      <= addr;
		din    <= data;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		for (int i = 0; i < 5; i++)
		begin
			@(negedge zclk);
			if (rd_valid)
			begin
				errors = errors + 1;
				$display("rd_valid pulsed during the write to port %h", addr);
			end
			@(posedge zclk);
			if (i == 2)
			begin
				iorq_n <= 1'b1;
				wr_n   <= 1'b1;
			end
		end
		model_write(addr, data);
		@(negedge zclk);
		check_regs();
	endtask

	// 4 cycles active, 2 idle, data checked at the rd_valid pulse
	task io_read(input logic [15:0] addr);
		logic [7:0] exp;
		bit         seen;
		@(posedge zclk);
		a      <= addr;
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		exp  = read_value(addr);
		seen = 1'b0;
		for (int i = 0; i < 6; i++)
		begin
			@(negedge zclk);
			if (rd_valid && seen)
			begin
				errors = errors + 1;
				$display("rd_valid stayed high for more than one cycle, port %h", addr);
			end
			else if (rd_valid)
			begin
				seen = 1'b1;
				if (rd_data !== exp)
				begin
					errors = errors + 1;
					$display("MISMATCH at %0t: read of port %h gave %h, expected %h",
						$time, addr, rd_data, exp);
				end
			end
			@(posedge zclk);
			if (i == 3)
			begin
				iorq_n <= 1'b1;
				rd_n   <= 1'b1;
			end
		end
		if (!seen)
		begin
			errors = errors + 1;
			$display("no read data came back for the read of port %h", addr);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// stimulus
	//////////////////////////////////////////////////////////////////////

	initial
	begin
		seed      = 32'h1494b91c;
		errors    = 0;
		cycles    = 0;
		rst_n     = 1'b0;
		a         = 16'h0000;
		din       = 8'h00;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		dos       = 1'b0;
		keys_in   = 5'h1F;
		tape_read = 1'b0;
		kj_in     = 5'h00;
		mus_in    = 8'hFF;
		dma_act   = 1'b0;

		// reset values
		apply_reset();
		@(negedge zclk);
		check_regs();
		check_val("xt_page after reset", xt_page, 32'h00020500);
		io_read(16'h0ABE);
		io_read(16'h0BBE);

		// xt paging and override
		io_write(16'h10AF, 8'h37);
		io_write(16'h11AF, 8'h41);
		io_write(16'h12AF, 8'h5A);
		io_write(16'h13AF, 8'h0C);
		io_write(16'h2AAF, 8'h05);
		io_write(16'h15AF, 8'h1F);
		io_write(16'h20AF, 8'h03);
		io_write(16'h25AF, 8'h80);
		io_write(16'h21AF, 8'h02);
		set_inputs(1'b0, 5'h1F, 1'b0, 5'h00, 8'hFF, 1'b1);
		io_read(16'h12AF);
		io_read(16'h13AF);
		io_read(16'h00AF);
		io_read(16'h20AF);
		io_read(16'h15AF);

		// 7ffd with and without lock128, then the bit 5 lock
		io_write(16'h21AF, 8'h40);
		io_write(16'h7FFD, 8'hD3);
		io_write(16'h21AF, 8'h00);
		io_write(16'h7FFD, 8'hC6);
		io_write(16'hFFFD, 8'h17); // ay address, not 7ffd
		io_write(16'h7FFD, 8'h25);
		io_write(16'h7FFD, 8'h07);
		io_read(16'h0ABE);

		// eff7 decode and masking
		set_inputs(1'b1, 5'h1F, 1'b0, 5'h00, 8'hFF, 1'b0);
		io_write(16'h01F7, 8'h0C);
		set_inputs(1'b0, 5'h1F, 1'b0, 5'h00, 8'hFF, 1'b0);
		io_write(16'h11F7, 8'h0C);
		io_write(16'h01F7, 8'hFF);
		io_read(16'h0BBE);
		io_write(16'h01F7, 8'h08);
		io_read(16'h0BBE);
		io_read(16'h0ABE);

		// keyboard, joystick, mouse
		set_inputs(1'b0, 5'h15, 1'b1, 5'h0A, 8'h9C, 1'b0);
		io_read(16'h00FE);
		io_read(16'h7FF6);
		io_read(16'h001F);
		io_read(16'h00DF);
		set_inputs(1'b1, 5'h0B, 1'b0, 5'h13, 8'h42, 1'b0);
		io_read(16'h001F); // vg93 space in dos
		io_read(16'hFEFE);

		// random mix from a fresh reset
		apply_reset();
		for (n = 0; n < 300; n++)
		begin
			r = $random(seed);
			set_inputs(r[1:0] == 2'b00, r[6:2], r[7], r[12:8], r[20:13], r[21]);
			r  = $random(seed);
			r2 = $random(seed);
			case (r[2:0])
				3'd0: lo = r[3] ? `ZP_FE : `ZP_F6;
				3'd1: lo = `ZP_AF;
				3'd2: lo = `ZP_FD;
				3'd3: lo = `ZP_F7;
				3'd4: lo = `ZP_BE;
				3'd5: lo = `ZP_KJOY;
				3'd6: lo = `ZP_KMOUSE;
				default: lo = r[15:8];
			endcase
			hi = r2[7:0];
			if (lo == `ZP_AF && r2[8])
			begin
				case (r2[12:9])
					4'd0: hi = `ZP_XSTAT;
					4'd1: hi = 8'h10;
					4'd2: hi = 8'h11;
					4'd3: hi = 8'h12;
					4'd4: hi = 8'h13;
					4'd5: hi = `ZP_FMADDR;
					4'd6: hi = `ZP_SYSCONF;
					4'd7: hi = `ZP_MEMCONF;
					4'd8: hi = `ZP_IM2VECT;
					4'd9: hi = `ZP_XTOVERR;
					default: hi = r2[7:0];
				endcase
			end
			if (lo == `ZP_BE)
				hi[3:0] = r2[9] ? `ZP_BE_P7FFD : `ZP_BE_PEFF7;
			d = r2[23:16];
			if (lo == `ZP_FD && d[5] && r2[27:24] != 4'h0)
				d[5] = 1'b0; // keep the 7ffd lock rare
			if (r2[31])
				io_write({hi, lo}, d);
			else
				io_read({hi, lo});
		end

		$display("run finished with %0d errors after %0d cycles", errors, cycles);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

// File: compile.f
+incdir+common
common/zport_pkg.sv
common/access_ifs.sv
hw/zbus_sync.sv
hw/port_decode.sv
hw/xt_regs/xt_regs.sv
hw/xt_regs/port_readback.sv
hw/zports_top.sv
tests/zports_tb.sv

// File: run.sh
#!/bin/sh
# build and run the port block testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary -f compile.f --top-module zports_tb -o zports_sim

./obj_dir/zports_sim > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
	exit 1
fi
exit 0
